// File: compile.f
hdl/icache_pkg.sv
hdl/icache_ctrl_fsm.sv
hdl/icache_fill_counter.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_lru.sv
hdl/icache_top.sv
tests/icache_props.sv
tests/icache_tb.sv

// File: hdl/icache_ctrl_fsm.sv
//////////////////////////////////////////////////
// Miss sequencer: issues the line request, waits
// for the fill, then re-reads for a waiting TL fetch
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_ctrl_fsm
  import icache_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          tv_miss_i,
  input  logic          tl_v_i,
  input  logic          fill_last_i,
  output logic          mem_req_v_o,
  output logic          fill_done_o,
  output logic          recover_o,
  output logic          ready_o,
  output icache_state_e state_o
);

  icache_state_e state_r;
  icache_state_e state_n;

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      st_ready:
        if (tv_miss_i)
          state_n = st_miss;
      st_miss:
        if (fill_last_i)
          state_n = tl_v_i ? st_recover : st_ready;
      // One cycle to re-read the memories for TL
      st_recover:
        state_n = st_ready;
      default:
        state_n = st_ready;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= st_ready;
    else
      state_r <= state_n;
  end

  // Request leaves in the first TV cycle of a miss
  assign mem_req_v_o = (state_r == st_ready) & tv_miss_i;
  assign fill_done_o = (state_r == st_miss) & fill_last_i;
  assign recover_o   = (state_r == st_recover);
  assign ready_o     = (state_r == st_ready);
  assign state_o     = state_r;

endmodule

// File: hdl/icache_data_array.sv
//////////////////////////////////////////////////
// Line storage, one bank per way; all ways read
// together, fill beats write one half-line each
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_data_array
  import icache_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rd_v_i,
  input  logic [INDEX_W-1:0]           rd_index_i,
  input  logic                         wr_v_i,
  input  logic [INDEX_W-1:0]           wr_index_i,
  input  logic [WAY_W-1:0]             wr_way_i,
  input  logic                         wr_beat_i,
  input  logic [FILL_W-1:0]            wr_data_i,
  output logic [WAYS-1:0][LINE_W-1:0]  rd_data_o
);

  logic [LINE_W-1:0] bank_r [WAYS][SETS];
  logic [WAYS-1:0][LINE_W-1:0] rd_data_r;

  //////////////////////////////////////////////////
  // Fill writes
  //////////////////////////////////////////////////

  // Low beat lands in bits 63:0, high beat in 127:64
  always_ff @(posedge clk_i)
  begin
    if (wr_v_i)
      bank_r[wr_way_i][wr_index_i][wr_beat_i*FILL_W +: FILL_W] <= wr_data_i;
  end

  //////////////////////////////////////////////////
  // Lookup reads
  //////////////////////////////////////////////////

  // Output holds the last read while no lookup is issued
  always_ff @(posedge clk_i)
  begin
    if (rd_v_i)
    begin
      for (int w = 0; w < WAYS; w++)
        rd_data_r[w] <= bank_r[w][rd_index_i];
    end
  end

  assign rd_data_o = rd_data_r;

endmodule

// File: hdl/icache_fill_counter.sv
//////////////////////////////////////////////////
// Fill beat counter; picks the half-line of each
// beat and flags the final beat of the line
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_fill_counter
  import icache_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic fill_v_i,
  output logic beat_o,
  output logic fill_last_o
);

  logic beat_r;

  // Last beat of the line in progress
  assign fill_last_o = fill_v_i & (beat_r == 1'(FILL_BEATS - 1));

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      beat_r <= 1'b0;
    else if (fill_v_i)
    begin
      if (fill_last_o)
        beat_r <= 1'b0;
      else
        beat_r <= beat_r + 1'b1;
    end
  end

  assign beat_o = beat_r;

endmodule

// File: hdl/icache_lru.sv
//////////////////////////////////////////////////
// Tree pseudo-LRU per set; updated on each use and
// consulted once per miss to pick the victim way
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_lru
  import icache_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [INDEX_W-1:0] tv_index_i,
  input  logic [WAYS-1:0]    way_v_i,
  input  logic               use_v_i,
  input  logic [WAY_W-1:0]   use_way_i,
  input  logic               req_fire_i,
  output logic [WAY_W-1:0]   victim_o
);

  // Bit 0 is the root, bit 1 covers ways 0-1, bit 2 covers ways 2-3
  logic [LRU_W-1:0] lru_r [SETS];
  logic [LRU_W-1:0] lru_set;
  logic [WAY_W-1:0] tree_way;
  logic [WAY_W-1:0] inv_way;
  logic             inv_found;
  logic [WAY_W-1:0] victim_r;

  assign lru_set = lru_r[tv_index_i];

  // Tree bits mark the recent side, the victim is on the other one
  assign tree_way[1] = ~lru_set[0];
  assign tree_way[0] = tree_way[1] ? ~lru_set[2] : ~lru_set[1];

  // Lowest invalid way
  always_comb
  begin
    inv_found = 1'b0;
    inv_way   = '0;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (!way_v_i[w])
      begin
        inv_found = 1'b1;
        inv_way   = WAY_W'(w);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < SETS; s++)
        lru_r[s] <= '0;
    end
    else if (use_v_i)
    begin
      lru_r[tv_index_i][0] <= use_way_i[1];
      if (use_way_i[1])
        lru_r[tv_index_i][2] <= use_way_i[0];
      else
        lru_r[tv_index_i][1] <= use_way_i[0];
    end
  end

  // Victim is fixed at request time and held through the fill
  always_ff @(posedge clk_i)
  begin
    if (req_fire_i)
      victim_r <= inv_found ? inv_way : tree_way;
  end

  assign victim_o = victim_r;

endmodule

// File: hdl/icache_pkg.sv
//////////////////////////////////////////////////
// Geometry, address views and FSM state for the
// instruction cache; imported by every cache block
//////////////////////////////////////////////////

package icache_pkg;

  // Fetch address and instruction
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;

  // Cache geometry
  localparam int WAYS       = 4;
  localparam int SETS       = 16;
  localparam int LINE_W     = 128;
  localparam int FILL_W     = 64;
  localparam int FILL_BEATS = 2;
  localparam int INDEX_W    = 4;
  localparam int WAY_W      = 2;
  localparam int LRU_W      = WAYS - 1;

  // Address field widths
  localparam int OFFSET_W   = 4;
  localparam int WORD_SEL_W = 2;
  localparam int BYTE_SEL_W = 2;
  localparam int LINE_NUM_W = ADDR_W - OFFSET_W;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

  //////////////////////////////////////////////////
  // Address views
  //////////////////////////////////////////////////

  // Lookup view drives the memories and the tag compare
  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [INDEX_W-1:0]    index;
    logic [WORD_SEL_W-1:0] word;
    logic [BYTE_SEL_W-1:0] byte_sel;
  } icache_lookup_s;

  // Line view forms the engine request
  typedef struct packed {
    logic [LINE_NUM_W-1:0] line_num;
    logic [OFFSET_W-1:0]   offset;
  } icache_line_s;

  typedef union packed {
    icache_lookup_s lookup;
    icache_line_s   line;
  } icache_addr_u;

  // Miss handling states
  typedef enum logic [1:0] {
    st_ready,
    st_miss,
    st_recover
  } icache_state_e;

endpackage

// File: hdl/icache_tag_array.sv
//////////////////////////////////////////////////
// Tag and valid storage for all ways; read one
// cycle ahead of the compare against the TL tag
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_tag_array
  import icache_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               rd_v_i,
  input  logic [INDEX_W-1:0] rd_index_i,
  input  logic [TAG_W-1:0]   tl_tag_i,
  input  logic               wr_v_i,
  input  logic [INDEX_W-1:0] wr_index_i,
  input  logic [WAY_W-1:0]   wr_way_i,
  input  logic [TAG_W-1:0]   wr_tag_i,
  output logic [WAYS-1:0]    hit_o,
  output logic [WAYS-1:0]    way_v_o
);

  logic [TAG_W-1:0] tag_r [SETS][WAYS];
  logic [WAYS-1:0]  valid_r [SETS];

  // Read port output, held between lookups
  logic [TAG_W-1:0] tag_rd_r [WAYS];
  logic [WAYS-1:0]  valid_rd_r;

  //////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < SETS; s++)
        valid_r[s] <= '0;
      valid_rd_r <= '0;
    end
    else
    begin
      if (wr_v_i)
        valid_r[wr_index_i][wr_way_i] <= 1'b1;
      if (rd_v_i)
        valid_rd_r <= valid_r[rd_index_i];
    end
  end

  //////////////////////////////////////////////////
  // Tags
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (wr_v_i)
      tag_r[wr_index_i][wr_way_i] <= wr_tag_i;
    if (rd_v_i)
    begin
      for (int w = 0; w < WAYS; w++)
        tag_rd_r[w] <= tag_r[rd_index_i][w];
    end
  end

  // Per-way compare, only valid ways can hit
  always_comb
  begin
    for (int w = 0; w < WAYS; w++)
      hit_o[w] = valid_rd_r[w] & (tag_rd_r[w] == tl_tag_i);
  end

  assign way_v_o = valid_rd_r;

endmodule

// File: hdl/icache_top.sv
//////////////////////////////////////////////////
// Instruction cache top: TL and TV stages, miss
// fill into the TV line buffer, result word select
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                v_i,
  input  icache_addr_u        addr_i,
  output logic                yumi_o,
  output logic [WORD_W-1:0]   data_o,
  output logic                data_v_o,
  input  logic                data_yumi_i,
  output logic                mem_req_v_o,
  output logic [ADDR_W-1:0]   mem_req_addr_o,
  input  logic                fill_v_i,
  input  logic [FILL_W-1:0]   fill_data_i
);

  icache_state_e state;
  logic          ready;
  logic          recover;
  logic          req_fire;
  logic          fill_done;
  logic          fill_last;
  logic          fill_beat;
  logic          fill_wr;
  logic          tl_v_r;
  icache_addr_u  tl_addr_r;
  logic          tl_adv;
  logic          tv_v_r;
  icache_addr_u  tv_addr_r;
  logic          tv_we;
  logic          tv_miss;
  logic          tv_complete_r;
  logic [WAYS-1:0]             tv_hit_r;
  logic [WAYS-1:0]             tv_way_v_r;
  logic [WAYS-1:0][LINE_W-1:0] tv_line_r;
  logic [WAYS-1:0]             tl_hit;
  logic [WAYS-1:0]             tl_way_v;
  logic [WAYS-1:0][LINE_W-1:0] rd_data;
  logic               rd_v;
  logic [INDEX_W-1:0] rd_index;
  logic [WAY_W-1:0]   victim;
  logic [WAY_W-1:0]   hit_way;
  logic               use_v;
  logic [LINE_W-1:0]  sel_line;

  //////////////////////////////////////////////////
  // Stage handshakes
  //////////////////////////////////////////////////

  assign data_v_o = tv_v_r & tv_complete_r;
  assign tv_we    = ~tv_v_r | (data_v_o & data_yumi_i);
  // TL waits out the recover re-read before moving on
  assign tl_adv   = tl_v_r & tv_we & ~recover;
  assign yumi_o   = v_i & ready & (~tl_v_r | tl_adv);
  assign tv_miss  = tv_v_r & ~tv_complete_r & ~(|tv_hit_r);
  assign fill_wr  = fill_v_i & (state == st_miss);

  // Lookup on accept, re-read of the TL address on recover
  assign rd_v     = yumi_o | recover;
  assign rd_index = recover ? tl_addr_r.lookup.index : addr_i.lookup.index;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_r <= 1'b0;
      tv_v_r <= 1'b0;
    end
    else
    begin
      if (yumi_o)
        tl_v_r <= 1'b1;
      else if (tl_adv)
        tl_v_r <= 1'b0;
      if (tl_adv)
        tv_v_r <= 1'b1;
      else if (data_v_o & data_yumi_i)
        tv_v_r <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // TL and TV payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i)
  begin
    if (yumi_o)
      tl_addr_r <= addr_i;
    if (tl_adv)
    begin
      tv_addr_r     <= tl_addr_r;
      tv_hit_r      <= tl_hit;
      tv_way_v_r    <= tl_way_v;
      tv_complete_r <= |tl_hit;
      tv_line_r     <= rd_data;
    end
    else
    begin
      // Fill beats go straight into the buffer of the victim way
      if (fill_wr)
        tv_line_r[victim][fill_beat*FILL_W +: FILL_W] <= fill_data_i;
      if (fill_done)
      begin
        tv_hit_r      <= WAYS'(1) << victim;
        tv_complete_r <= 1'b1;
      end
    end
  end

  // Hit way and word select
  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      if (tv_hit_r[w])
        hit_way = WAY_W'(w);
    end
  end

  assign sel_line = tv_line_r[hit_way];
  assign data_o   = sel_line[tv_addr_r.lookup.word*WORD_W +: WORD_W];

  // Line-aligned request address
  assign mem_req_v_o    = req_fire;
  assign mem_req_addr_o = {tv_addr_r.line.line_num, {OFFSET_W{1'b0}}};

  assign use_v = (data_v_o & data_yumi_i) | fill_done;

  //////////////////////////////////////////////////
  // Submodules
  //////////////////////////////////////////////////

  icache_ctrl_fsm u_fsm (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tv_miss_i   (tv_miss),
    .tl_v_i      (tl_v_r),
    .fill_last_i (fill_last),
    .mem_req_v_o (req_fire),
    .fill_done_o (fill_done),
    .recover_o   (recover),
    .ready_o     (ready),
    .state_o     (state)
  );

  icache_fill_counter u_fill_cnt (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fill_v_i    (fill_wr),
    .beat_o      (fill_beat),
    .fill_last_o (fill_last)
  );

  icache_tag_array u_tags (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_v_i     (rd_v),
    .rd_index_i (rd_index),
    .tl_tag_i   (tl_addr_r.lookup.tag),
    .wr_v_i     (fill_done),
    .wr_index_i (tv_addr_r.lookup.index),
    .wr_way_i   (victim),
    .wr_tag_i   (tv_addr_r.lookup.tag),
    .hit_o      (tl_hit),
    .way_v_o    (tl_way_v)
  );

  icache_data_array u_data (
    .clk_i      (clk_i),
    .rd_v_i     (rd_v),
    .rd_index_i (rd_index),
    .wr_v_i     (fill_wr),
    .wr_index_i (tv_addr_r.lookup.index),
    .wr_way_i   (victim),
    .wr_beat_i  (fill_beat),
    .wr_data_i  (fill_data_i),
    .rd_data_o  (rd_data)
  );

  icache_lru u_lru (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .tv_index_i (tv_addr_r.lookup.index),
    .way_v_i    (tv_way_v_r),
    .use_v_i    (use_v),
    .use_way_i  (fill_done ? victim : hit_way),
    .req_fire_i (req_fire),
    .victim_o   (victim)
  );

endmodule

// File: tests/icache_props.sv
//////////////////////////////////////////////////
// Port assertions, bound into the cache top level
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_props
  import icache_pkg::*;
(
  input logic              clk_i,
  input logic              reset_i,
  input icache_state_e     state_i,
  input logic              yumi_i,
  input logic              mem_req_v_i,
  input logic              data_v_i,
  input logic              data_yumi_i,
  input logic [WORD_W-1:0] data_i
);

  // A line request is a single pulse that starts miss handling
  req_in_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_i |=> (state_i == st_miss && !mem_req_v_i))
    else $error("line request did not start a single miss");

  // Result holds while the sink stalls
  data_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (data_v_i && !data_yumi_i) |=> (data_v_i && $stable(data_i)))
    else $error("result changed or dropped under stall");

  // No fetch accepted once a miss is under way
  yumi_in_ready: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_v_i |=> !yumi_i)
    else $error("fetch accepted during miss handling");

endmodule

bind icache_top icache_props u_props (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .state_i     (state),
  .yumi_i      (yumi_o),
  .mem_req_v_i (mem_req_v_o),
  .data_v_i    (data_v_o),
  .data_yumi_i (data_yumi_i),
  .data_i      (data_o)
);

// File: tests/icache_tb.sv
//////////////////////////////////////////////////
// Cache testbench: replays the fetch vectors, models
// the memory engine and checks every returned word
//////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
;

  localparam int    N_VEC           = 20;
  localparam int    WATCHDOG_CYCLES = N_VEC * 40 + 200;
  localparam string VEC_FILE        = "tests/icache_vectors.txt";

  logic              clk_i = 1'b0;
  logic              reset_i;
  logic              v_i;
  icache_addr_u      addr_i;
  logic              yumi_o;
  logic [WORD_W-1:0] data_o;
  logic              data_v_o;
  logic              data_yumi_i;
  logic              mem_req_v_o;
  logic [ADDR_W-1:0] mem_req_addr_o;
  logic              fill_v_i;
  logic [FILL_W-1:0] fill_data_i;

  // Three entries per vector line
  logic [31:0] vec_mem [0:3*N_VEC-1];
  logic [31:0] vec_addr [N_VEC];
  int          vec_stall [N_VEC];
  logic        vec_miss [N_VEC];
  logic [31:0] req_lines [$];
  int          errors;
  int          checks;
  int          req_count;
  integer      seed;

  always #2 clk_i = ~clk_i;

  icache_top uut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .v_i            (v_i),
    .addr_i         (addr_i),
    .yumi_o         (yumi_o),
    .data_o         (data_o),
    .data_v_o       (data_v_o),
    .data_yumi_i    (data_yumi_i),
    .mem_req_v_o    (mem_req_v_o),
    .mem_req_addr_o (mem_req_addr_o),
    .fill_v_i       (fill_v_i),
    .fill_data_i    (fill_data_i)
  );

  // Engine data rule, word at byte address A
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    begin
      checks++;
      if (got !== exp)
      begin
        errors++;
        $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      end
    end
  endtask

  task automatic expect_idle(input int cycles);
    begin
      repeat (cycles)
      begin
        @(negedge clk_i);
        compare_value("yumi_o", yumi_o, 32'd0);
        compare_value("data_v_o", data_v_o, 32'd0);
        compare_value("mem_req_v_o", mem_req_v_o, 32'd0);
      end
    end
  endtask

  task automatic load_vectors;
    begin
      $readmemh(VEC_FILE, vec_mem);
      for (int i = 0; i < N_VEC; i++)
      begin
        if ($isunknown({vec_mem[3*i], vec_mem[3*i+1], vec_mem[3*i+2]}))
        begin
          errors++;
          $display("Vector %0d is missing or unreadable in the vector file", i);
        end
        vec_addr[i]  = vec_mem[3*i];
        vec_stall[i] = vec_mem[3*i+1];
        vec_miss[i]  = vec_mem[3*i+2][0];
        // Each miss should send its line address, in fetch order
        if (vec_miss[i])
          req_lines.push_back({vec_addr[i][31:4], 4'h0});
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // Fetch source and result sink
  ////////////////////////////////////////////////////

  task automatic drive_fetches;
    begin
      for (int i = 0; i < N_VEC; i++)
      begin
        v_i    = 1'b1;
        addr_i = vec_addr[i];
        #1;
        while (yumi_o !== 1'b1)
        begin
          @(negedge clk_i);
          #1;
        end
        @(negedge clk_i);
      end
      v_i = 1'b0;
    end
  endtask

  task automatic consume_results;
    logic [31:0] held;
    int          exp_misses;
    begin
      exp_misses = 0;
      for (int k = 0; k < N_VEC; k++)
      begin
        while (data_v_o !== 1'b1)
          @(negedge clk_i);
        // Requests so far must match the misses up to this fetch
        exp_misses += vec_miss[k];
        compare_value("mem_req_v_o count", req_count, exp_misses);
        compare_value("data_o", data_o, expected_word(vec_addr[k]));
        held = data_o;
        for (int s = 0; s < vec_stall[k]; s++)
        begin
          @(negedge clk_i);
          compare_value("data_v_o", data_v_o, 32'd1);
          compare_value("data_o", data_o, held);
          // Stalled result keeps the next fetch waiting
          compare_value("yumi_o", yumi_o, 32'd0);
        end
        data_yumi_i = 1'b1;
        @(negedge clk_i);
        data_yumi_i = 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // Memory engine
  ////////////////////////////////////////////////////

  task automatic serve_line(input logic [31:0] line_addr);
    logic [31:0] exp_line;
    int          gap;
    begin
      if (req_lines.size() == 0)
      begin
        errors++;
        $display("Unexpected line request to %h at t=%0t, no miss was due", line_addr, $time);
      end
      else
      begin
        exp_line = req_lines.pop_front();
        compare_value("mem_req_addr_o", line_addr, exp_line);
      end
      gap = ($random(seed) & 3) + 1;
      repeat (gap) @(negedge clk_i);
      // Low beat first
      fill_v_i    = 1'b1;
      fill_data_i = {expected_word(line_addr + 4), expected_word(line_addr)};
      @(negedge clk_i);
      fill_data_i = {expected_word(line_addr + 12), expected_word(line_addr + 8)};
      @(negedge clk_i);
      fill_v_i    = 1'b0;
      fill_data_i = '0;
    end
  endtask

  initial
  begin
    @(negedge reset_i);
    forever
    begin
      @(negedge clk_i);
      if (mem_req_v_o === 1'b1)
      begin
        req_count++;
        serve_line(mem_req_addr_o);
      end
    end
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, the fetch stream never completed", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    seed        = 32'hd3b8fb9a;
    errors      = 0;
    checks      = 0;
    req_count   = 0;
    reset_i     = 1'b1;
    v_i         = 1'b0;
    addr_i      = '0;
    data_yumi_i = 1'b0;
    fill_v_i    = 1'b0;
    fill_data_i = '0;
    load_vectors();
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    // Outputs stay quiet until the first fetch
    expect_idle(5);
    fork
      drive_fetches();
      consume_results();
    join
    // No extra result and no stray request
    expect_idle(10);
    if (req_lines.size() != 0)
    begin
      errors++;
      $display("%0d expected line requests were never issued", req_lines.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tests/icache_vectors.txt
// Columns: fetch address, sink stall cycles, expected miss flag (all hex)
// Miss flag 1 means the fetch sends one line request
00001000 0 1
00001004 0 0
00001008 0 0
0000100c 2 0
00002010 0 1
00003020 1 1
// Five lines into set 3, then revisits under pseudo-LRU
00004030 0 1
00005034 0 1
00006038 0 1
0000703c 0 1
00008030 3 1
00005030 0 0
00004034 0 1
00007030 1 0
00006030 0 1
00008034 0 1
00005038 2 0
// Hits on earlier lines
0000100c 3 0
00003024 0 0
00002018 1 0
